// File: include/lsu_cfg.svh
// Load/store unit configuration

`ifndef LSU_CFG_SVH
`define LSU_CFG_SVH

// data path and address width in bits.
`define LSU_XLEN 64

// depth of the data RAM, in 64-bit words.
`define LSU_MEM_WORDS 256

// word index width, taken from address bits above the byte offset.
// must cover LSU_MEM_WORDS exactly so that addresses wrap cleanly.
`define LSU_IDX_W 8

`endif

// File: src/lsu_pkg.sv
// Load/store unit types

`include "lsu_cfg.svh"

package lsu_pkg;

  // memory operation code, low bit marks unsigned loads.
  typedef enum logic [2:0] {
    OP_B    = 3'b000,
    OP_BU   = 3'b001,
    OP_H    = 3'b010,
    OP_HU   = 3'b011,
    OP_W    = 3'b100,
    OP_WU   = 3'b101,
    OP_D    = 3'b110,
    OP_NONE = 3'b111
  } mem_op_t;

  typedef logic [7:0] byte_mask_t; // one bit per byte lane.

  typedef logic [`LSU_XLEN-1:0] word_t;

  // OP_D shares the low bit pattern but is a full word.
  function automatic logic op_unsigned(mem_op_t op);
    return op[0] && (op != OP_D);
  endfunction

  // offset bits that must be zero for an aligned access.
  function automatic logic [2:0] op_align_mask(mem_op_t op);
    case (op)
      OP_H, OP_HU: return 3'b001;
      OP_W, OP_WU: return 3'b011;
      OP_D:        return 3'b111;
      default:     return 3'b000;
    endcase
  endfunction

endpackage

// File: src/key_mux.sv
// Keyed lookup multiplexer

`timescale 1ns/1ps

module key_mux #(
  parameter int  NR_KEY  = 2,
  parameter int  KEY_LEN = 1,
  parameter type T       = logic [7:0]
) (
  input  logic [KEY_LEN-1:0]           i_key,
  input  logic [KEY_LEN+$bits(T)-1:0]  i_lut [NR_KEY],
  input  T                             i_default,
  output T                             o_out
);

  localparam int DATA_W = $bits(T);

  logic hit; // first match wins.

  // each entry is {key, value}, key in the upper bits.
  always_comb begin
    o_out = i_default;
    hit   = 1'b0;
    for (int k = 0; k < NR_KEY; k++) begin
      if (!hit && (i_lut[k][KEY_LEN+DATA_W-1 -: KEY_LEN] == i_key)) begin
        o_out = T'(i_lut[k][DATA_W-1:0]);
        hit   = 1'b1;
      end
    end
  end

endmodule

// File: src/lane_encode.sv
// Store lane encoder

`timescale 1ns/1ps

module lane_encode (
  input  lsu_pkg::mem_op_t    i_op,
  input  logic [2:0]          i_offset,
  input  lsu_pkg::word_t      i_wdata,
  output lsu_pkg::byte_mask_t o_mask,
  output lsu_pkg::word_t      o_wdata,
  output logic                o_misaligned
);

  import lsu_pkg::*;

  localparam int KEY_W = $bits(mem_op_t);
  localparam int LUT_W = KEY_W + $bits(byte_mask_t);

  // size mask per op, OP_NONE falls to the empty default.
  localparam logic [LUT_W-1:0] MASK_LUT [7] = '{
    {OP_B,  8'b0000_0001},
    {OP_BU, 8'b0000_0001},
    {OP_H,  8'b0000_0011},
    {OP_HU, 8'b0000_0011},
    {OP_W,  8'b0000_1111},
    {OP_WU, 8'b0000_1111},
    {OP_D,  8'b1111_1111}
  };

  byte_mask_t size_mask; // enables before lane shift.

  key_mux #(
    .NR_KEY  (7),
    .KEY_LEN (KEY_W),
    .T       (byte_mask_t)
  ) u_mask_lut (
    .i_key     (i_op),
    .i_lut     (MASK_LUT),
    .i_default ('0),
    .o_out     (size_mask)
  );

  // move enables and data up into the addressed lanes.
  assign o_mask  = size_mask << i_offset;
  assign o_wdata = i_wdata << {i_offset, 3'b000};

  // offset must be a multiple of the access size.
  assign o_misaligned = |(i_offset & op_align_mask(i_op));

endmodule

// File: src/load_align.sv
// Load data alignment

`timescale 1ns/1ps

`include "lsu_cfg.svh"

module load_align (
  input  lsu_pkg::mem_op_t i_op,
  input  logic [2:0]       i_offset,
  input  lsu_pkg::word_t   i_word,
  input  logic             i_kill,
  output lsu_pkg::word_t   o_data
);

  import lsu_pkg::*;

  localparam int XW    = `LSU_XLEN;
  localparam int LUT_W = 3 + $bits(word_t);

  logic [LUT_W-1:0] shift_lut [8];
  word_t            shifted;   // addressed bytes at bit 0.
  word_t            ext;
  logic             fill;      // sign fill enable.

  // one entry per byte offset, built from the live RAM word.
  always_comb begin
    for (int k = 0; k < 8; k++) begin
      shift_lut[k] = {3'(k), i_word >> (8 * k)};
    end
  end

  key_mux #(
    .NR_KEY  (8),
    .KEY_LEN (3),
    .T       (word_t)
  ) u_shift_lut (
    .i_key     (i_offset),
    .i_lut     (shift_lut),
    .i_default (i_word),
    .o_out     (shifted)
  );

  always_comb begin
    fill = !op_unsigned(i_op);
    case (i_op)
      OP_B, OP_BU: ext = {{(XW-8){fill & shifted[7]}}, shifted[7:0]};
      OP_H, OP_HU: ext = {{(XW-16){fill & shifted[15]}}, shifted[15:0]};
      OP_W, OP_WU: ext = {{(XW-32){fill & shifted[31]}}, shifted[31:0]};
      OP_D:        ext = shifted;
      default:     ext = '0; // no access.
    endcase
  end

  assign o_data = i_kill ? '0 : ext;

endmodule

// File: src/data_ram.sv
// Byte-enabled data RAM

`timescale 1ns/1ps

`include "lsu_cfg.svh"

module data_ram (
  input  logic                  i_clk,
  input  logic                  i_we,
  input  logic                  i_re,
  input  logic [`LSU_IDX_W-1:0] i_idx,
  input  lsu_pkg::byte_mask_t   i_mask,
  input  lsu_pkg::word_t        i_wdata,
  output lsu_pkg::word_t        o_rdata
);

  import lsu_pkg::*;

  localparam int NB = $bits(byte_mask_t);

  word_t mem [`LSU_MEM_WORDS];

  // only enabled lanes are touched.
  always_ff @(posedge i_clk) begin
    if (i_we) begin
      for (int b = 0; b < NB; b++) begin
        if (i_mask[b]) begin
          mem[i_idx][8*b +: 8] <= i_wdata[8*b +: 8];
        end
      end
    end
  end

  // registered read, output held between reads.
  always_ff @(posedge i_clk) begin
    if (i_re) begin
      o_rdata <= mem[i_idx];
    end
  end

endmodule

// File: src/data_mem.sv
// Data memory stage

`timescale 1ns/1ps

`include "lsu_cfg.svh"

module data_mem (
  input  logic             i_clk,
  input  logic             i_rst,
  input  logic             i_req,
  input  logic             i_we,
  input  lsu_pkg::word_t   i_addr,
  input  lsu_pkg::word_t   i_wdata,
  input  lsu_pkg::mem_op_t i_op,
  output logic             o_rd_valid,
  output lsu_pkg::word_t   o_rd_data,
  output logic             o_err
);

  import lsu_pkg::*;

  logic [`LSU_IDX_W-1:0] idx;     // wraps on the index bits.
  logic [2:0]            offset;
  byte_mask_t            lane_mask;
  word_t                 lane_wdata;
  logic                  misaligned;
  logic                  active;  // request that touches memory.
  logic                  ram_we;
  logic                  ram_re;
  word_t                 ram_rdata;

  // response stage, one cycle behind the request.
  mem_op_t               op_q;
  logic [2:0]            offset_q;
  logic                  rd_pend_q;
  logic                  err_q;

  assign idx    = i_addr[`LSU_IDX_W+2:3];
  assign offset = i_addr[2:0];

  lane_encode u_lane_encode (
    .i_op         (i_op),
    .i_offset     (offset),
    .i_wdata      (i_wdata),
    .o_mask       (lane_mask),
    .o_wdata      (lane_wdata),
    .o_misaligned (misaligned)
  );

  assign active = i_req && (i_op != OP_NONE);
  assign ram_we = active && i_we && !misaligned;
  assign ram_re = active && !i_we; // misaligned data is killed later.

  data_ram u_data_ram (
    .i_clk   (i_clk),
    .i_we    (ram_we),
    .i_re    (ram_re),
    .i_idx   (idx),
    .i_mask  (lane_mask),
    .i_wdata (lane_wdata),
    .o_rdata (ram_rdata)
  );

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      op_q      <= OP_NONE;
      offset_q  <= '0;
      rd_pend_q <= 1'b0;
      err_q     <= 1'b0;
    end else begin
      op_q      <= i_op;
      offset_q  <= offset;
      rd_pend_q <= active && !i_we;
      err_q     <= active && misaligned; // loads and stores alike.
    end
  end

  // zero out rejected loads and idle cycles.
  load_align u_load_align (
    .i_op     (op_q),
    .i_offset (offset_q),
    .i_word   (ram_rdata),
    .i_kill   (err_q || !rd_pend_q),
    .o_data   (o_rd_data)
  );

  assign o_rd_valid = rd_pend_q;
  assign o_err      = err_q;

endmodule

// File: tests/data_mem_assertions.sv
// Data memory protocol assertions

`timescale 1ns/1ps

module data_mem_assertions (
  input logic             i_clk,
  input logic             i_rst,
  input logic             i_req,
  input logic             i_we,
  input lsu_pkg::mem_op_t i_op,
  input logic             o_rd_valid,
  input lsu_pkg::word_t   o_rd_data,
  input logic             o_err
);

  import lsu_pkg::*;

  logic load_req; // load that reaches the RAM.

  assign load_req = i_req && !i_we && (i_op != OP_NONE);

  // quiet through reset and the first cycle after it.
  a_reset_quiet: assert property (@(posedge i_clk) i_rst |=> (!o_rd_valid && !o_err))
    else $error("response active during reset or right after it");

  a_valid_has_load: assert property (
    @(posedge i_clk) disable iff (i_rst) o_rd_valid |-> $past(load_req)
  ) else $error("read response without a load one cycle before");

  // rejected requests return zero.
  a_err_zero_data: assert property (
    @(posedge i_clk) disable iff (i_rst) o_err |-> (o_rd_data == '0)
  ) else $error("error flag raised with nonzero read data");

endmodule

// File: tests/data_mem_tb.sv
// Data memory stage testbench

`timescale 1ns/1ps

`include "lsu_cfg.svh"

module data_mem_tb;

  import lsu_pkg::*;

  localparam int NBYTES = `LSU_MEM_WORDS * 8;
  localparam int ABITS  = `LSU_IDX_W + 3; // byte address bits that wrap.

  logic    i_clk;
  logic    i_rst;
  logic    i_req;
  logic    i_we;
  word_t   i_addr;
  word_t   i_wdata;
  mem_op_t i_op;
  logic    o_rd_valid;
  word_t   o_rd_data;
  logic    o_err;

  logic [7:0] model_mem [NBYTES];
  logic       exp_valid_q [$]; // one entry per driven cycle.
  logic       exp_err_q [$];
  word_t      exp_data_q [$];
  integer     seed;
  int         value_errors;
  int         other_errors;

  data_mem u_data_mem (
    .i_clk      (i_clk),
    .i_rst      (i_rst),
    .i_req      (i_req),
    .i_we       (i_we),
    .i_addr     (i_addr),
    .i_wdata    (i_wdata),
    .i_op       (i_op),
    .o_rd_valid (o_rd_valid),
    .o_rd_data  (o_rd_data),
    .o_err      (o_err)
  );

  bind data_mem data_mem_assertions u_data_mem_assertions (
    .i_clk      (i_clk),
    .i_rst      (i_rst),
    .i_req      (i_req),
    .i_we       (i_we),
    .i_op       (i_op),
    .o_rd_valid (o_rd_valid),
    .o_rd_data  (o_rd_data),
    .o_err      (o_err)
  );

  initial begin
    i_clk = 1'b0;
    forever #5 i_clk = ~i_clk;
  end

  function automatic logic [31:0] rand32();
    return $random(seed);
  endfunction

  function automatic word_t rand64();
    return {rand32(), rand32()};
  endfunction

  function automatic word_t word_addr(logic [`LSU_IDX_W-1:0] idx, logic [2:0] off);
    return {{(64-ABITS){1'b0}}, idx, off};
  endfunction

  function automatic int op_bytes(mem_op_t op);
    case (op)
      OP_B, OP_BU: return 1;
      OP_H, OP_HU: return 2;
      OP_W, OP_WU: return 4;
      OP_D:        return 8;
      default:     return 0; // no access.
    endcase
  endfunction

  function automatic logic is_misaligned(mem_op_t op, word_t addr);
    int n;
    n = op_bytes(op);
    return (n > 1) && ((int'(addr[2:0]) % n) != 0);
  endfunction

  // gather bytes little endian, then extend by hand.
  function automatic word_t model_load(mem_op_t op, word_t addr);
    int    n;
    int    base;
    word_t val;
    n    = op_bytes(op);
    base = int'(addr[ABITS-1:0]);
    val  = '0;
    for (int b = 0; b < n; b++) begin
      val[8*b +: 8] = model_mem[base + b];
    end
    if ((op == OP_B || op == OP_H || op == OP_W) && val[8*n-1]) begin
      for (int b = 8 * n; b < 64; b++) begin
        val[b] = 1'b1;
      end
    end
    return val;
  endfunction

  task automatic model_store(input mem_op_t op, input word_t addr, input word_t wdata);
    int base;
    base = int'(addr[ABITS-1:0]);
    for (int b = 0; b < op_bytes(op); b++) begin
      model_mem[base + b] = wdata[8*b +: 8];
    end
  endtask

  task automatic check_word(input string name, input word_t exp, input word_t act);
    if (act !== exp) begin
      value_errors++;
      $display("FAIL t=%0t %s expected %h got %h", $time, name, exp, act);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      value_errors++;
      $display("FAIL t=%0t %s expected %0b got %0b", $time, name, exp, act);
    end
  endtask

  // check last cycle's response on the falling edge.
  task automatic next_cycle();
    @(negedge i_clk);
    if (exp_valid_q.size() > 0) begin
      check_flag("o_rd_valid", exp_valid_q.pop_front(), o_rd_valid);
      check_flag("o_err", exp_err_q.pop_front(), o_err);
      check_word("o_rd_data", exp_data_q.pop_front(), o_rd_data);
    end
  endtask

  task automatic send(input logic we, input word_t addr, input word_t wdata, input mem_op_t op);
    logic bad;
    next_cycle();
    i_req   = 1'b1;
    i_we    = we;
    i_addr  = addr;
    i_wdata = wdata;
    i_op    = op;
    bad = is_misaligned(op, addr);
    exp_valid_q.push_back(!we && op != OP_NONE);
    exp_err_q.push_back(bad);
    if (!we && op != OP_NONE && !bad) begin
      exp_data_q.push_back(model_load(op, addr));
    end else begin
      exp_data_q.push_back('0);
    end
    if (we && op != OP_NONE && !bad) begin
      model_store(op, addr, wdata);
    end
  endtask

  task automatic idle();
    next_cycle();
    i_req = 1'b0;
    i_we  = 1'(rand32());  // junk on the idle inputs.
    i_op  = mem_op_t'(3'(rand32()));
    exp_valid_q.push_back(1'b0);
    exp_err_q.push_back(1'b0);
    exp_data_q.push_back('0);
  endtask

  task automatic random_traffic(input int cycles);
    logic [31:0] r;
    word_t       addr;
    word_t       last_addr;
    mem_op_t     op;
    int          n;
    last_addr = '0;
    for (int c = 0; c < cycles; c++) begin
      r    = rand32();
      op   = mem_op_t'(r[2:0]);
      addr = rand64(); // high bits exercise wrapping.
      n    = op_bytes(op);
      if (r[5:4] == 2'b00) begin
        addr[ABITS-1:3] = last_addr[ABITS-1:3];
      end
      if (r[10:9] != 2'b00 && n > 0) begin
        addr[2:0] = 3'(int'(addr[2:0]) / n * n);
      end
      if (r[8:6] == 3'b000) begin
        idle();
      end else begin
        send(r[3], addr, rand64(), op);
      end
      last_addr = addr;
    end
  endtask

  initial begin
    word_t   addr;
    mem_op_t op;
    int      guard;
    seed = 49826;
    value_errors = 0;
    other_errors = 0;
    i_rst   = 1'b1;
    i_req   = 1'b0;
    i_we    = 1'b0;
    i_addr  = '0;
    i_wdata = '0;
    i_op    = OP_NONE;
    repeat (4) @(posedge i_clk);
    @(negedge i_clk);
    i_rst = 1'b0;
    guard = 0;
    while ((o_rd_valid !== 1'b0 || o_err !== 1'b0) && guard < 8) begin
      @(negedge i_clk);
      guard++;
    end
    if (guard == 8) begin
      other_errors++;
      $display("timeout: outputs did not go idle after reset");
    end

    // fill every word so the model starts defined.
    for (int w = 0; w < `LSU_MEM_WORDS; w++) begin
      send(1'b1, word_addr(w[`LSU_IDX_W-1:0], 3'd0), rand64(), OP_D);
    end

    // every op at every aligned and misaligned offset.
    for (int k = 0; k < 7; k++) begin
      op = mem_op_t'(k[2:0]);
      for (int off = 0; off < 8; off++) begin
        addr = word_addr(8'(rand32()), off[2:0]);
        send(1'b1, addr, rand64(), op);
        send(1'b0, addr, '0, op);
        send(1'b0, {addr[63:3], 3'b000}, '0, OP_D);
      end
    end

    for (int i = 0; i < 16; i++) begin
      addr = word_addr(8'(rand32()), 3'(rand32()));
      send(1'b1, addr, rand64(), OP_NONE);
      send(1'b0, addr, '0, OP_NONE);
      send(1'b0, {addr[63:3], 3'b000}, '0, OP_D);
    end

    // far addresses alias onto the low words.
    for (int i = 0; i < 16; i++) begin
      addr = word_addr(8'(rand32()), 3'd0);
      send(1'b1, addr | (rand64() << ABITS), rand64(), OP_D);
      send(1'b0, addr, '0, OP_D);
      send(1'b0, addr | (rand64() << ABITS), '0, OP_D);
    end

    random_traffic(3000);

    idle();
    next_cycle();

    $display("errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// File: all.f
+incdir+include
src/lsu_pkg.sv
src/key_mux.sv
src/lane_encode.sv
src/load_align.sv
src/data_ram.sv
src/data_mem.sv
tests/data_mem_assertions.sv
tests/data_mem_tb.sv

// File: Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := data_mem_tb
FILELIST := all.f
OBJ_DIR  := obj_dir

BIN      := $(OBJ_DIR)/V$(TOP)
SRCS     := $(shell grep -v '^+' $(FILELIST)) $(wildcard include/*.svh)
PASS_MSG := *** TEST PASSED ***

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
